// File: source/g729_frame_pkg.sv
package g729_frame_pkg;

	////////////////////
	// Frame layout

	localparam int PRM_SIZE       = 11;
	localparam int SERIAL_SIZE    = 82;
	localparam int FRAME_BITS     = 80;
	localparam int FIRST_BIT_ADDR = 2;

	typedef logic [15:0] word_t;
	typedef logic [6:0]  frame_addr_t;
	typedef logic [3:0]  prm_addr_t;
	typedef logic [4:0]  bit_count_t;

	////////////////////
	// Serial word codes

	localparam word_t SYNC_WORD = 16'h6b21;
	localparam word_t BIT_0     = 16'h007f;
	localparam word_t BIT_1     = 16'h0081;

	// Bits per parameter, in bitstream order (sums to FRAME_BITS)
	localparam bit_count_t PRM_WIDTHS [PRM_SIZE] = '{
		5'd8, 5'd10, 5'd8, 5'd1,
		5'd13, 5'd4, 5'd7,
		5'd5, 5'd13, 5'd4, 5'd7
	};

endpackage

// File: source/host_bus_pkg.sv
package host_bus_pkg;

	////////////////////
	// Bus transfer

	typedef struct packed {
		logic        write;
		logic [11:0] addr;
		logic [15:0] wdata;
	} host_req_t;

	typedef struct packed {
		logic [15:0] rdata;
	} host_rsp_t;

	// Address map
	localparam logic [11:0] FRAME_BASE  = 12'h000;
	localparam logic [11:0] PRM_BASE    = 12'h100;
	localparam logic [11:0] CTRL_ADDR   = 12'h200;
	localparam logic [11:0] STATUS_ADDR = 12'h201;

	////////////////////
	// Status word

	localparam int STAT_BUSY = 0;
	localparam int STAT_DONE = 1;
	localparam int STAT_BFI  = 2;

	typedef struct packed {
		logic bfi;
		logic done;
		logic busy;
	} unpack_status_t;

endpackage

// File: source/frame_word_ram.sv
`timescale 1ns/1ps

module frame_word_ram #(
	parameter int DEPTH = 82
) (
	input  logic                         clk,
	input  logic                         we,
	input  logic [$clog2(DEPTH)-1:0]     waddr,
	input  g729_frame_pkg::word_t        wdata,
	input  logic [$clog2(DEPTH)-1:0]     raddr,
	output g729_frame_pkg::word_t        rdata
);

	g729_frame_pkg::word_t mem [DEPTH];

	// Addresses past the end are dropped
	always_ff @(posedge clk) begin
		if (we && (int'(waddr) < DEPTH)) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read, old data on a same-cycle write
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

// File: source/bits_to_int.sv
`timescale 1ns/1ps

module bits_to_int (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        start,
	input  g729_frame_pkg::bit_count_t  count,
	input  g729_frame_pkg::frame_addr_t first_addr,
	output g729_frame_pkg::frame_addr_t rd_addr,
	input  g729_frame_pkg::word_t       rd_data,
	output logic                        done,
	output g729_frame_pkg::word_t       value,
	output logic                        invalid
);

	typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE} state_t;

	state_t                      state;
	g729_frame_pkg::frame_addr_t addr;
	g729_frame_pkg::bit_count_t  to_issue;
	logic                        issue;
	logic                        rd_valid;

	assign issue   = (state == S_RUN) && (to_issue != '0);
	assign rd_addr = addr;
	assign done    = (state == S_DONE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= S_IDLE;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= issue;
			case (state)
				S_IDLE: if (start) state <= S_RUN;
				// Last word is back once nothing is left to issue
				S_RUN: if (rd_valid && (to_issue == '0)) state <= S_DONE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == S_IDLE) && start) begin
			addr     <= first_addr;
			to_issue <= count;
			value    <= '0;
			invalid  <= 1'b0;
		end else begin
			if (issue) begin
				addr     <= addr + 1'b1;
				to_issue <= to_issue - 1'b1;
			end
			if (rd_valid) begin
				// MSB first, anything but BIT_1 counts as zero
				value <= {value[14:0], rd_data == g729_frame_pkg::BIT_1};
				if ((rd_data != g729_frame_pkg::BIT_0) && (rd_data != g729_frame_pkg::BIT_1))
					invalid <= 1'b1;
			end
		end
	end

	a_count_range: assert property (@(posedge clk) disable iff (reset)
		$rose(start) |-> (count >= 5'd1) && (count <= 5'd16));

endmodule

// File: source/prm_unpacker.sv
`timescale 1ns/1ps

module prm_unpacker (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        start,
	output g729_frame_pkg::frame_addr_t frame_rd_addr,
	input  g729_frame_pkg::word_t       frame_rd_data,
	output logic                        prm_we,
	output g729_frame_pkg::prm_addr_t   prm_waddr,
	output g729_frame_pkg::word_t       prm_wdata,
	output logic                        finish,
	output logic                        bfi
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_SYNC_RD,
		S_SIZE_RD,
		S_SIZE_CHK,
		S_BITS,
		S_WRITE,
		S_FINISH
	} state_t;

	state_t                      state;
	g729_frame_pkg::prm_addr_t   i;
	g729_frame_pkg::frame_addr_t bit_addr;
	logic                        hdr_fault;
	logic                        bit_fault;

	logic                        b2i_start;
	g729_frame_pkg::frame_addr_t b2i_rd_addr;
	logic                        b2i_done;
	g729_frame_pkg::word_t       b2i_value;
	logic                        b2i_invalid;

	bits_to_int u_bits_to_int (
		.clk        (clk),
		.reset      (reset),
		.start      (b2i_start),
		.count      (g729_frame_pkg::PRM_WIDTHS[i]),
		.first_addr (bit_addr),
		.rd_addr    (b2i_rd_addr),
		.rd_data    (frame_rd_data),
		.done       (b2i_done),
		.value      (b2i_value),
		.invalid    (b2i_invalid)
	);

	assign b2i_start = (state == S_BITS);
	assign prm_we    = (state == S_WRITE);
	assign prm_waddr = i;
	assign prm_wdata = b2i_value;
	assign finish    = (state == S_FINISH);
	assign bfi       = hdr_fault | bit_fault;

	// Header words go out on the frame read port first and bits_to_int follows
	always_comb begin
		case (state)
			S_SIZE_RD: frame_rd_addr = g729_frame_pkg::frame_addr_t'(1);
			S_BITS:    frame_rd_addr = b2i_rd_addr;
			default:   frame_rd_addr = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= S_IDLE;
			i         <= '0;
			bit_addr  <= '0;
			hdr_fault <= 1'b0;
			bit_fault <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (start) begin
					state     <= S_SYNC_RD;
					i         <= '0;
					bit_addr  <= g729_frame_pkg::frame_addr_t'(g729_frame_pkg::FIRST_BIT_ADDR);
					hdr_fault <= 1'b0;
					bit_fault <= 1'b0;
				end
				S_SYNC_RD: state <= S_SIZE_RD;
				S_SIZE_RD: begin
					// Sync word is on the read port now
					if (frame_rd_data != g729_frame_pkg::SYNC_WORD) hdr_fault <= 1'b1;
					state <= S_SIZE_CHK;
				end
				S_SIZE_CHK: begin
					if (frame_rd_data != 16'(g729_frame_pkg::FRAME_BITS)) hdr_fault <= 1'b1;
					state <= S_BITS;
				end
				S_BITS: if (b2i_done) begin
					if (b2i_invalid) bit_fault <= 1'b1;
					state <= S_WRITE;
				end
				S_WRITE: begin
					bit_addr <= bit_addr
						+ g729_frame_pkg::frame_addr_t'(g729_frame_pkg::PRM_WIDTHS[i]);
					i <= i + 1'b1;
					if (i == g729_frame_pkg::prm_addr_t'(g729_frame_pkg::PRM_SIZE - 1))
						state <= S_FINISH;
					else
						state <= S_BITS;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// bits_to_int only reports a result while a parameter is being assembled
	a_done_in_bits: assert property (@(posedge clk) disable iff (reset)
		b2i_done |-> (state == S_BITS));

endmodule

// File: source/unpack_regs.sv
`timescale 1ns/1ps

module unpack_regs (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        req,
	input  host_bus_pkg::host_req_t     host_req,
	output logic                        ack,
	output host_bus_pkg::host_rsp_t     host_rsp,
	output logic                        frame_we,
	output g729_frame_pkg::frame_addr_t frame_waddr,
	output g729_frame_pkg::word_t       frame_wdata,
	output g729_frame_pkg::prm_addr_t   prm_raddr,
	input  g729_frame_pkg::word_t       prm_rdata,
	output logic                        start,
	input  logic                        finish,
	input  logic                        bfi,
	output logic                        busy
);

	typedef enum logic [1:0] {R_IDLE, R_READ, R_ACK} bus_state_t;

	bus_state_t                   state;
	host_bus_pkg::unpack_status_t status;
	logic [11:0]                  frame_off;
	logic [11:0]                  prm_off;
	logic                         in_frame;
	logic                         in_prm;
	logic                         accept;
	logic                         start_cmd;
	logic [15:0]                  rdata_mux;

	////////////////////
	// Address decode

	assign accept    = (state == R_IDLE) && req;
	assign frame_off = host_req.addr - host_bus_pkg::FRAME_BASE;
	assign prm_off   = host_req.addr - host_bus_pkg::PRM_BASE;
	assign in_frame  = frame_off < 12'(g729_frame_pkg::SERIAL_SIZE);
	assign in_prm    = prm_off < 12'(g729_frame_pkg::PRM_SIZE);

	assign frame_we    = accept && host_req.write && in_frame && !status.busy;
	assign frame_waddr = g729_frame_pkg::frame_addr_t'(frame_off);
	assign frame_wdata = host_req.wdata;
	assign prm_raddr   = g729_frame_pkg::prm_addr_t'(prm_off);

	assign start_cmd = accept && host_req.write && (host_req.addr == host_bus_pkg::CTRL_ADDR)
		&& host_req.wdata[0] && !status.busy;

	assign ack  = (state == R_ACK);
	assign busy = status.busy;

	////////////////////
	// Handshake

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= R_IDLE;
		end else begin
			case (state)
				// Reads wait one more cycle for the RAM
				R_IDLE: if (req) state <= host_req.write ? R_ACK : R_READ;
				R_READ: state <= R_ACK;
				R_ACK:  if (!req) state <= R_IDLE;
				default: state <= R_IDLE;
			endcase
		end
	end

	always_comb begin
		rdata_mux = '0;
		if (in_prm) begin
			rdata_mux = prm_rdata;
		end else if (host_req.addr == host_bus_pkg::STATUS_ADDR) begin
			rdata_mux[host_bus_pkg::STAT_BUSY] = status.busy;
			rdata_mux[host_bus_pkg::STAT_DONE] = status.done;
			rdata_mux[host_bus_pkg::STAT_BFI]  = status.bfi;
		end
	end

	always_ff @(posedge clk) begin
		if (state == R_READ) host_rsp.rdata <= rdata_mux;
	end

	// Control and status
	always_ff @(posedge clk) begin
		if (reset) begin
			start  <= 1'b0;
			status <= '0;
		end else begin
			start <= start_cmd;
			if (start_cmd) begin
				status.busy <= 1'b1;
				status.done <= 1'b0;
			end else if (finish) begin
				status.busy <= 1'b0;
				status.done <= 1'b1;
				status.bfi  <= bfi;
			end
		end
	end

	a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> req && $past(req));

endmodule

// File: source/bitstream_unpacker_top.sv
`timescale 1ns/1ps

module bitstream_unpacker_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    req,
	input  host_bus_pkg::host_req_t host_req,
	output logic                    ack,
	output host_bus_pkg::host_rsp_t host_rsp
);

	logic                        busy;
	logic                        start;
	logic                        finish;
	logic                        bfi;

	logic                        frame_we;
	g729_frame_pkg::frame_addr_t frame_waddr;
	g729_frame_pkg::word_t       frame_wdata;
	g729_frame_pkg::frame_addr_t frame_raddr;
	g729_frame_pkg::word_t       frame_rdata;
	g729_frame_pkg::frame_addr_t unpk_frame_raddr;

	logic                        prm_we;
	g729_frame_pkg::prm_addr_t   prm_waddr;
	g729_frame_pkg::word_t       prm_wdata;
	g729_frame_pkg::prm_addr_t   prm_raddr;
	g729_frame_pkg::word_t       prm_rdata;

	// Unpacker owns the frame read port while busy, parked at the sync word otherwise
	assign frame_raddr = busy ? unpk_frame_raddr : '0;

	unpack_regs u_regs (
		.clk         (clk),
		.reset       (reset),
		.req         (req),
		.host_req    (host_req),
		.ack         (ack),
		.host_rsp    (host_rsp),
		.frame_we    (frame_we),
		.frame_waddr (frame_waddr),
		.frame_wdata (frame_wdata),
		.prm_raddr   (prm_raddr),
		.prm_rdata   (prm_rdata),
		.start       (start),
		.finish      (finish),
		.bfi         (bfi),
		.busy        (busy)
	);

	frame_word_ram #(.DEPTH(g729_frame_pkg::SERIAL_SIZE)) u_frame_ram (
		.clk   (clk),
		.we    (frame_we),
		.waddr (frame_waddr),
		.wdata (frame_wdata),
		.raddr (frame_raddr),
		.rdata (frame_rdata)
	);

	frame_word_ram #(.DEPTH(g729_frame_pkg::PRM_SIZE)) u_prm_ram (
		.clk   (clk),
		.we    (prm_we),
		.waddr (prm_waddr),
		.wdata (prm_wdata),
		.raddr (prm_raddr),
		.rdata (prm_rdata)
	);

	prm_unpacker u_unpacker (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.frame_rd_addr (unpk_frame_raddr),
		.frame_rd_data (frame_rdata),
		.prm_we        (prm_we),
		.prm_waddr     (prm_waddr),
		.prm_wdata     (prm_wdata),
		.finish        (finish),
		.bfi           (bfi)
	);

endmodule

// File: sim/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
	output logic clk,
	output logic reset
);

	localparam int HALF_PERIOD_NS = 50;
	localparam int RESET_CYCLES   = 5;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD_NS) clk = ~clk;
	end

	// Reset held over the first rising edges
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// File: sim/tb_unpacker.sv
`timescale 1ns/1ps

module tb_unpacker;

	localparam int CLK_PERIOD_NS = 100;
	localparam int ACK_LIMIT     = 16;
	// Ten decodes, each budgeted as a full frame load plus a decode
	localparam int FRAME_RUNS       = 10;
	localparam int CYCLES_PER_FRAME = 84 * 8 + 300;
	localparam int WATCHDOG_NS      = 2 * FRAME_RUNS * CYCLES_PER_FRAME * CLK_PERIOD_NS;

	// Bits per parameter in bitstream order
	localparam int LAYOUT [g729_frame_pkg::PRM_SIZE] = '{8, 10, 8, 1, 13, 4, 7, 5, 13, 4, 7};

	typedef struct packed {
		logic                                                 bfi;
		g729_frame_pkg::word_t [g729_frame_pkg::PRM_SIZE-1:0] prm;
	} ref_result_t;

	logic                    clk;
	logic                    reset;
	logic                    req;
	logic                    ack;
	host_bus_pkg::host_req_t host_req;
	host_bus_pkg::host_rsp_t host_rsp;

	g729_frame_pkg::word_t   frame_img [g729_frame_pkg::SERIAL_SIZE];
	logic [31:0]             rand_state;
	logic                    last_bfi;

	clock_gen u_clock_gen (
		.clk   (clk),
		.reset (reset)
	);

	bitstream_unpacker_top DUT (
		.clk      (clk),
		.reset    (reset),
		.req      (req),
		.host_req (host_req),
		.ack      (ack),
		.host_rsp (host_rsp)
	);

	////////////////////
	// Error handling and checks

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input g729_frame_pkg::word_t got,
		input g729_frame_pkg::word_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at time %0t: %s read %04h, expected %04h",
				$time, what, got, exp));
	endtask

	task automatic check_status(input host_bus_pkg::unpack_status_t got,
		input host_bus_pkg::unpack_status_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at time %0t: %s busy/done/bfi %b%b%b, expected %b%b%b",
				$time, what, got.busy, got.done, got.bfi, exp.busy, exp.done, exp.bfi));
	endtask

	function automatic host_bus_pkg::unpack_status_t status_of(input logic busy,
		input logic done, input logic bfi);
		host_bus_pkg::unpack_status_t st;
		st.busy = busy;
		st.done = done;
		st.bfi  = bfi;
		return st;
	endfunction

	////////////////////
	// Reference model and stimulus

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic ref_result_t ref_unpack(
		input g729_frame_pkg::word_t frame [g729_frame_pkg::SERIAL_SIZE]);
		ref_result_t r;
		int pos;
		r = '0;
		r.bfi = (frame[0] != g729_frame_pkg::SYNC_WORD) || (frame[1] != 16'd80);
		for (int a = 2; a < g729_frame_pkg::SERIAL_SIZE; a++) begin
			if ((frame[a] != g729_frame_pkg::BIT_0) && (frame[a] != g729_frame_pkg::BIT_1))
				r.bfi = 1'b1;
		end
		// MSB first, only the exact one-bit code reads as one
		pos = 2;
		for (int p = 0; p < g729_frame_pkg::PRM_SIZE; p++) begin
			for (int b = 0; b < LAYOUT[p]; b++) begin
				r.prm[p] = {r.prm[p][14:0], frame[pos] == g729_frame_pkg::BIT_1};
				pos++;
			end
		end
		return r;
	endfunction

	task automatic build_frame(input g729_frame_pkg::word_t sync, input g729_frame_pkg::word_t size);
		g729_frame_pkg::word_t value;
		int pos;
		frame_img[0] = sync;
		frame_img[1] = size;
		pos = 2;
		for (int p = 0; p < g729_frame_pkg::PRM_SIZE; p++) begin
			rand_state = lcg_next(rand_state);
			value = rand_state[31:16];
			for (int b = LAYOUT[p] - 1; b >= 0; b--) begin
				frame_img[pos] = value[b] ? g729_frame_pkg::BIT_1 : g729_frame_pkg::BIT_0;
				pos++;
			end
		end
	endtask

	////////////////////
	// Host bus

	task automatic wait_for_ack(input logic level, input string what);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (ack !== level) begin
			cycles++;
			if (cycles > ACK_LIMIT)
				abort_run($sformatf("Handshake stalled: ack never went to %0b during %s",
					level, what));
			@(negedge clk);
		end
	endtask

	task automatic bus_write(input logic [11:0] addr, input g729_frame_pkg::word_t data);
		@(posedge clk);
		req      <= 1'b1;
		host_req <= '{write: 1'b1, addr: addr, wdata: data};
		wait_for_ack(1'b1, $sformatf("write to %03h", addr));
		@(posedge clk);
		req <= 1'b0;
		wait_for_ack(1'b0, $sformatf("write to %03h", addr));
	endtask

	task automatic bus_read(input logic [11:0] addr, output g729_frame_pkg::word_t data);
		@(posedge clk);
		req      <= 1'b1;
		host_req <= '{write: 1'b0, addr: addr, wdata: 16'h0000};
		wait_for_ack(1'b1, $sformatf("read of %03h", addr));
		data = host_rsp.rdata;
		@(posedge clk);
		req <= 1'b0;
		wait_for_ack(1'b0, $sformatf("read of %03h", addr));
	endtask

	task automatic read_status(output host_bus_pkg::unpack_status_t st);
		g729_frame_pkg::word_t rd;
		bus_read(host_bus_pkg::STATUS_ADDR, rd);
		check_word({rd[15:3], 3'b000}, 16'h0000, "status upper bits");
		st = host_bus_pkg::unpack_status_t'(rd[2:0]);
	endtask

	task automatic load_words(input int first, input int last);
		for (int a = first; a <= last; a++)
			bus_write(host_bus_pkg::FRAME_BASE + 12'(a), frame_img[a]);
	endtask

	// Status polls show busy with done cleared until the decode ends
	task automatic wait_done();
		host_bus_pkg::unpack_status_t st;
		int busy_polls;
		busy_polls = 0;
		read_status(st);
		while (!st.done) begin
			check_status(st, status_of(1'b1, 1'b0, last_bfi), "status while decoding");
			busy_polls++;
			read_status(st);
		end
		if (busy_polls == 0)
			abort_run("Decode reported done before any status poll saw it busy");
	endtask

	task automatic check_results();
		ref_result_t exp;
		g729_frame_pkg::word_t rd;
		host_bus_pkg::unpack_status_t st;
		exp = ref_unpack(frame_img);
		for (int p = 0; p < g729_frame_pkg::PRM_SIZE; p++) begin
			bus_read(host_bus_pkg::PRM_BASE + 12'(p), rd);
			check_word(rd, exp.prm[p], $sformatf("parameter %0d", p));
		end
		read_status(st);
		check_status(st, status_of(1'b0, 1'b1, exp.bfi), "status after decode");
		last_bfi = exp.bfi;
	endtask

	task automatic decode_and_check();
		bus_write(host_bus_pkg::CTRL_ADDR, 16'h0001);
		wait_done();
		check_results();
	endtask

	////////////////////
	// Tests

	initial begin
		g729_frame_pkg::word_t rd;
		host_bus_pkg::unpack_status_t st;
		req        = 1'b0;
		host_req   = '0;
		rand_state = 32'hd4b6;
		last_bfi   = 1'b0;
		wait (reset === 1'b0);

		// Idle status, then one write and one read handshake
		read_status(st);
		check_status(st, status_of(1'b0, 1'b0, 1'b0), "status after reset");
		bus_write(host_bus_pkg::FRAME_BASE, g729_frame_pkg::SYNC_WORD);
		bus_read(host_bus_pkg::PRM_BASE, rd);

		// Clean random frame
		build_frame(g729_frame_pkg::SYNC_WORD, 16'd80);
		load_words(0, g729_frame_pkg::SERIAL_SIZE - 1);
		decode_and_check();

		// Bad sync word, then bad size with only the header rewritten
		build_frame(16'h6b20, 16'd80);
		load_words(0, g729_frame_pkg::SERIAL_SIZE - 1);
		decode_and_check();
		frame_img[0] = g729_frame_pkg::SYNC_WORD;
		frame_img[1] = 16'd79;
		load_words(0, 1);
		decode_and_check();

		// One bit word with an illegal code
		build_frame(g729_frame_pkg::SYNC_WORD, 16'd80);
		frame_img[40] = 16'h0181;
		load_words(0, g729_frame_pkg::SERIAL_SIZE - 1);
		decode_and_check();

		// Start and frame writes during a decode must be dropped
		build_frame(g729_frame_pkg::SYNC_WORD, 16'd80);
		load_words(0, g729_frame_pkg::SERIAL_SIZE - 1);
		bus_write(host_bus_pkg::CTRL_ADDR, 16'h0001);
		bus_write(host_bus_pkg::CTRL_ADDR, 16'h0001);
		for (int a = 2; a < 10; a++)
			bus_write(host_bus_pkg::FRAME_BASE + 12'(a), 16'hffff);
		read_status(st);
		check_status(st, status_of(1'b1, 1'b0, last_bfi), "status after writes while busy");
		wait_done();
		check_results();
		// Same buffer decoded again gives the same result
		decode_and_check();

		// Back-to-back frames, bfi toggling between them
		for (int k = 0; k < 4; k++) begin
			build_frame(g729_frame_pkg::SYNC_WORD, 16'd80);
			if (k % 2 == 1)
				frame_img[10 + 7 * k] = 16'h0000;
			load_words(0, g729_frame_pkg::SERIAL_SIZE - 1);
			decode_and_check();
		end

		$display("Test completed successfully");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run($sformatf("Watchdog expired: run still going after %0d ns", WATCHDOG_NS));
	end

endmodule

// File: filelist.f
source/g729_frame_pkg.sv
source/host_bus_pkg.sv
source/frame_word_ram.sv
source/bits_to_int.sv
source/prm_unpacker.sv
source/unpack_regs.sv
source/bitstream_unpacker_top.sv
sim/clock_gen.sv
sim/tb_unpacker.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_unpacker \
	-f filelist.f -Mdir obj_dir

./obj_dir/Vtb_unpacker > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
